// ==== verilog/sha3_pad_pkg.sv ====
/*
  Shared widths, types and constants of the SHA3/SHAKE padding stage
  Message words are fixed at 64 bits with byte strobes, no other width
  Only SHA3 and SHAKE suffixes exist here; cSHAKE prefixes are not supported
*/
`default_nettype none

package sha3_pad_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // One message beat and its byte enables
  localparam int MsgWidth = 64;
  localparam int MsgStrbW = MsgWidth / 8;

  // Largest rate is 1344 bits (SHAKE128), 21 words
  localparam int MsgEntries = 21;

  // Count must reach MsgEntries itself to flag a full block
  localparam int MsgCountW = $clog2(MsgEntries + 1);

  typedef logic [MsgWidth-1:0]  msg_word_t;
  typedef logic [MsgStrbW-1:0]  msg_strb_t;
  typedef logic [MsgCountW-1:0] word_cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Modes and strengths
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    Sha3  = 1'b0,
    Shake = 1'b1
  } sha3_mode_e;

  // Security strength in bits, selects the rate
  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } keccak_strength_e;

  // Write source of the block buffer
  typedef enum logic [1:0] {
    SrcNone    = 2'b00,
    SrcMsg     = 2'b01,
    SrcPad     = 2'b10,
    SrcZeroEnd = 2'b11
  } sel_src_e;

  // Rate in 64-bit words, indexed by keccak_strength_e
  localparam word_cnt_t KeccakRateWords [5] = '{5'd21, 5'd18, 5'd17, 5'd13, 5'd9};

  // Function suffix with the leading 1 of pad10*1 already appended
  // SHA3 appends 01, SHAKE appends 1111, both LSB first
  localparam logic [4:0] SuffixSha3  = 5'b00110;
  localparam logic [4:0] SuffixShake = 5'b11111;

endpackage

`default_nettype wire

// ==== verilog/msg_tail_buffer.sv ====
/*
  Holds the partial last word of a message until the pad word is written
  A partial word has contiguous strobes from byte 0 and byte 7 always empty
  Only one partial word per message, and only as its last word
*/
`timescale 1ns/1ps
`default_nettype none

module msg_tail_buffer (
  input  logic                     clk_i,
  input  logic                     rst_b,
  input  sha3_pad_pkg::msg_word_t  msg_data_i,
  input  sha3_pad_pkg::msg_strb_t  msg_strb_i,
  input  sha3_pad_pkg::sha3_mode_e mode_i,
  input  logic                     latch_tail_i,
  input  logic                     clr_tail_i,
  input  logic                     end_of_block_i,
  output logic                     tail_partial_o,
  output sha3_pad_pkg::msg_word_t  pad_word_o
);
  import sha3_pad_pkg::*;

  // Low seven bytes only, byte 7 is never valid in a partial word
  logic [MsgWidth-9:0] tail_data_q;
  logic [MsgStrbW-2:0] tail_strb_q;

  // Suffix plus first pad bit for the current mode
  logic [4:0] suffix;

  // Any cleared strobe marks the tail of the message
  assign tail_partial_o = ~(&msg_strb_i);

  assign suffix = (mode_i == Shake) ? SuffixShake : SuffixSha3;

  // Strobes decide which bytes survive, so they carry the reset
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      tail_strb_q <= '0;
    end else if (latch_tail_i) begin
      tail_strb_q <= msg_strb_i[MsgStrbW-2:0];
    end else if (clr_tail_i) begin
      tail_strb_q <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_tail_i) begin
      tail_data_q <= msg_data_i[MsgWidth-9:0];
    end else if (clr_tail_i) begin
      tail_data_q <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pad word merge
  //////////////////////////////////////////////////////////////////////

  // Suffix goes into the first empty byte, end bit of pad10*1 at bit 63
  always_comb begin
    unique case (tail_strb_q)
      7'b000_0000: pad_word_o = {end_of_block_i, 63'(suffix)};
      7'b000_0001: pad_word_o = {end_of_block_i, 55'(suffix), tail_data_q[7:0]};
      7'b000_0011: pad_word_o = {end_of_block_i, 47'(suffix), tail_data_q[15:0]};
      7'b000_0111: pad_word_o = {end_of_block_i, 39'(suffix), tail_data_q[23:0]};
      7'b000_1111: pad_word_o = {end_of_block_i, 31'(suffix), tail_data_q[31:0]};
      7'b001_1111: pad_word_o = {end_of_block_i, 23'(suffix), tail_data_q[39:0]};
      7'b011_1111: pad_word_o = {end_of_block_i, 15'(suffix), tail_data_q[47:0]};
      7'b111_1111: pad_word_o = {end_of_block_i, 7'(suffix), tail_data_q[55:0]};
      // Broken strobes, keep only the end bit
      default:     pad_word_o = {end_of_block_i, 63'b0};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // A latched tail is a nonempty run of bytes from byte 0
  TailStrbContiguous_A: assert property (@(posedge clk_i) disable iff (!rst_b)
    latch_tail_i |=> (tail_strb_q != '0) &&
                     ((tail_strb_q & 7'(tail_strb_q + 1'b1)) == '0));

endmodule

`default_nettype wire

// ==== verilog/pad_ctrl_fsm.sv ====
/*
  Padding control: block word counter, run requests and absorbed pulse
  mode_i and strength_i must hold from start_i until absorbed_o
  Only one block is in flight, the count clears with every run
*/
`timescale 1ns/1ps
`default_nettype none

module pad_ctrl_fsm (
  input  logic                           clk_i,
  input  logic                           rst_b,
  input  logic                           start_i,
  input  logic                           process_i,
  input  logic                           msg_valid_i,
  input  logic                           tail_partial_i,
  input  logic                           keccak_ready_i,
  input  logic                           keccak_complete_i,
  input  sha3_pad_pkg::keccak_strength_e strength_i,
  output logic                           msg_ready_o,
  output logic                           keccak_run_o,
  output logic                           absorbed_o,
  output logic                           latch_tail_o,
  output logic                           clr_tail_o,
  output logic                           wr_en_o,
  output logic                           clr_buf_o,
  output logic                           end_of_block_o,
  output sha3_pad_pkg::sel_src_e         sel_src_o,
  output sha3_pad_pkg::word_cnt_t        wr_addr_o
);
  import sha3_pad_pkg::*;

  typedef enum logic [2:0] {
    Idle    = 3'd0,
    Message = 3'd1,
    Pad     = 3'd2,
    Pad01   = 3'd3,
    PadRun  = 3'd4,
    Flush   = 3'd5
  } pad_state_e;

  pad_state_e state_q;
  pad_state_e state_d;

  // Words written into the current block
  word_cnt_t wr_cnt_q;
  word_cnt_t block_limit;
  logic      block_full;

  // process_i seen while a full block waited for its run
  logic process_q;
  logic process_pending;

  logic absorbed_d;

  //////////////////////////////////////////////////////////////////////
  // Block size and counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (strength_i)
      L128:    block_limit = KeccakRateWords[0];
      L224:    block_limit = KeccakRateWords[1];
      L256:    block_limit = KeccakRateWords[2];
      L384:    block_limit = KeccakRateWords[3];
      L512:    block_limit = KeccakRateWords[4];
      default: block_limit = KeccakRateWords[0];
    endcase
  end

  assign block_full      = (wr_cnt_q == block_limit);
  // Next write lands in the last word of the block
  assign end_of_block_o  = (word_cnt_t'(wr_cnt_q + 1'b1) == block_limit);
  assign wr_addr_o       = wr_cnt_q;
  assign process_pending = process_q | process_i;

  // Clears together with the buffer, steps on each word write
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      wr_cnt_q <= '0;
    end else if (clr_buf_o) begin
      wr_cnt_q <= '0;
    end else if (wr_en_o) begin
      wr_cnt_q <= word_cnt_t'(wr_cnt_q + 1'b1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end else if (start_i) begin
      process_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      state_q    <= Idle;
      absorbed_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      absorbed_o <= absorbed_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    sel_src_o    = SrcNone;
    msg_ready_o  = 1'b0;
    keccak_run_o = 1'b0;
    latch_tail_o = 1'b0;
    clr_tail_o   = 1'b0;
    wr_en_o      = 1'b0;
    clr_buf_o    = 1'b0;
    absorbed_d   = 1'b0;

    unique case (state_q)
      Idle: begin
        if (start_i) begin
          state_d = Message;
        end
      end

      // Full block first, even when process is already pending
      Message: begin
        sel_src_o = SrcMsg;
        if (block_full) begin
          if (keccak_ready_i) begin
            keccak_run_o = 1'b1;
            clr_buf_o    = 1'b1;
          end
        end else if (process_pending) begin
          state_d = Pad;
        end else begin
          msg_ready_o = 1'b1;
          // Partial word goes to the tail buffer, full word to the block
          if (msg_valid_i) begin
            latch_tail_o = tail_partial_i;
            wr_en_o      = ~tail_partial_i;
          end
        end
      end

      // Suffix-merged word, may already be the last of the block
      Pad: begin
        sel_src_o = SrcPad;
        if (keccak_ready_i) begin
          wr_en_o    = 1'b1;
          clr_tail_o = 1'b1;
          state_d    = end_of_block_o ? PadRun : Pad01;
        end
      end

      // Zero fill up to the block end, last word carries bit 63
      Pad01: begin
        sel_src_o = SrcZeroEnd;
        if (keccak_ready_i) begin
          if (block_full) begin
            keccak_run_o = 1'b1;
            clr_buf_o    = 1'b1;
            state_d      = Flush;
          end else begin
            wr_en_o = 1'b1;
          end
        end
      end

      PadRun: begin
        if (keccak_ready_i) begin
          keccak_run_o = 1'b1;
          clr_buf_o    = 1'b1;
          state_d      = Flush;
        end
      end

      // Wait for the last permutation
      Flush: begin
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          state_d    = Idle;
        end
      end

      default: begin
        state_d = Idle;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  StartPulse_A: assert property (@(posedge clk_i) disable iff (!rst_b)
    start_i |=> !start_i);

  ProcessPulse_A: assert property (@(posedge clk_i) disable iff (!rst_b)
    process_i |=> !process_i);

  // Count must clear right after a run, or a second run would follow
  KeccakRunPulse_A: assert property (@(posedge clk_i) disable iff (!rst_b)
    keccak_run_o |=> !keccak_run_o);

  WrAddrInBlock_A: assert property (@(posedge clk_i) disable iff (!rst_b)
    wr_en_o |-> wr_addr_o < block_limit);

endmodule

`default_nettype wire

// ==== verilog/block_buffer.sv ====
/*
  Block-wide buffer read by Keccak, word 0 in the low bits
  Entries beyond the current rate stay zero, a clear wipes all entries
  Contents hold while no write or clear is requested
*/
`timescale 1ns/1ps
`default_nettype none

module block_buffer (
  input  logic                    clk_i,
  input  logic                    rst_b,
  input  sha3_pad_pkg::sel_src_e  sel_src_i,
  input  logic                    wr_en_i,
  input  logic                    clr_buf_i,
  input  logic                    end_of_block_i,
  input  sha3_pad_pkg::word_cnt_t wr_addr_i,
  input  sha3_pad_pkg::msg_word_t msg_data_i,
  input  sha3_pad_pkg::msg_word_t pad_word_i,
  output sha3_pad_pkg::msg_word_t [sha3_pad_pkg::MsgEntries-1:0] keccak_data_o
);
  import sha3_pad_pkg::*;

  // Word selected for the next write
  msg_word_t wr_word;

  //////////////////////////////////////////////////////////////////////
  // Write source
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (sel_src_i)
      SrcMsg:     wr_word = msg_data_i;
      SrcPad:     wr_word = pad_word_i;
      // Zero fill, last word of the block closes pad10*1
      SrcZeroEnd: wr_word = {end_of_block_i, {(MsgWidth-1){1'b0}}};
      SrcNone:    wr_word = '0;
      default:    wr_word = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // Keccak absorbs the whole rate, so stale words must never remain
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      keccak_data_o <= '0;
    end else if (clr_buf_i) begin
      keccak_data_o <= '0;
    end else if (wr_en_i) begin
      for (int unsigned i = 0; i < MsgEntries; i++) begin
        // Addressed entry only
        if (wr_addr_i == word_cnt_t'(i)) begin
          keccak_data_o[i] <= wr_word;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sha3_pad_top.sv ====
/*
  SHA3/SHAKE padding stage in front of a Keccak permutation
  start_i and process_i are single-cycle pulses, never in the same cycle
  Only the last message word may be partial; absorbed_o ends a message
*/
`timescale 1ns/1ps
`default_nettype none

module sha3_pad_top (
  input  logic                           clk_i,
  input  logic                           rst_b,

  // Message source
  input  logic                           msg_valid_i,
  input  sha3_pad_pkg::msg_word_t        msg_data_i,
  input  sha3_pad_pkg::msg_strb_t        msg_strb_i,
  output logic                           msg_ready_o,

  // Control
  input  logic                           start_i,
  input  logic                           process_i,
  input  sha3_pad_pkg::sha3_mode_e       mode_i,
  input  sha3_pad_pkg::keccak_strength_e strength_i,

  // Keccak side
  output sha3_pad_pkg::msg_word_t [sha3_pad_pkg::MsgEntries-1:0] keccak_data_o,
  input  logic                           keccak_ready_i,
  output logic                           keccak_run_o,
  input  logic                           keccak_complete_i,
  output logic                           absorbed_o
);
  import sha3_pad_pkg::*;

  // Tail buffer to block buffer
  msg_word_t pad_word;

  // FSM to datapath
  sel_src_e  sel_src;
  word_cnt_t wr_addr;
  logic      wr_en;
  logic      clr_buf;
  logic      end_of_block;
  logic      latch_tail;
  logic      clr_tail;

  // Tail buffer to FSM
  logic      tail_partial;

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  msg_tail_buffer u_msg_tail_buffer (
    .clk_i          (clk_i),
    .rst_b          (rst_b),
    .msg_data_i     (msg_data_i),
    .msg_strb_i     (msg_strb_i),
    .mode_i         (mode_i),
    .latch_tail_i   (latch_tail),
    .clr_tail_i     (clr_tail),
    .end_of_block_i (end_of_block),
    .tail_partial_o (tail_partial),
    .pad_word_o     (pad_word)
  );

  // Control
  pad_ctrl_fsm u_pad_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .start_i           (start_i),
    .process_i         (process_i),
    .msg_valid_i       (msg_valid_i),
    .tail_partial_i    (tail_partial),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_complete_i (keccak_complete_i),
    .strength_i        (strength_i),
    .msg_ready_o       (msg_ready_o),
    .keccak_run_o      (keccak_run_o),
    .absorbed_o        (absorbed_o),
    .latch_tail_o      (latch_tail),
    .clr_tail_o        (clr_tail),
    .wr_en_o           (wr_en),
    .clr_buf_o         (clr_buf),
    .end_of_block_o    (end_of_block),
    .sel_src_o         (sel_src),
    .wr_addr_o         (wr_addr)
  );

  // Output side
  block_buffer u_block_buffer (
    .clk_i          (clk_i),
    .rst_b          (rst_b),
    .sel_src_i      (sel_src),
    .wr_en_i        (wr_en),
    .clr_buf_i      (clr_buf),
    .end_of_block_i (end_of_block),
    .wr_addr_i      (wr_addr),
    .msg_data_i     (msg_data_i),
    .pad_word_i     (pad_word),
    .keccak_data_o  (keccak_data_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_sha3_pad_cases.svh ====
/*
  Stimulus table, LFSR and expected-block builder for tb_sha3_pad
  Included inside the testbench module, after the sha3_pad_pkg import
  Expected streams follow pad10*1 with the SHA3 or SHAKE suffix byte
*/
`ifndef TB_SHA3_PAD_CASES_SVH
`define TB_SHA3_PAD_CASES_SVH

localparam logic [31:0] LfsrSeed = 32'had489443;
// x^32 + x^22 + x^2 + x + 1, right-shifting Galois form
localparam logic [31:0] LfsrTaps = 32'h80200003;
localparam int          NumCases = 8;

// Mode, strength in bits, length in bytes, back-pressure, blocks expected
typedef struct packed {
  sha3_mode_e  mode;
  logic [9:0]  bits;
  logic [15:0] len;
  logic        bp;
  logic [3:0]  blocks;
} case_row_t;

case_row_t case_table [NumCases];

task automatic load_cases();
  case_table[0] = '{Sha3,  10'd256, 16'd5,   1'b0, 4'd1};
  // Two full blocks, third block is pure padding
  case_table[1] = '{Shake, 10'd128, 16'd336, 1'b0, 4'd3};
  // Suffix and end bit share the last byte
  case_table[2] = '{Sha3,  10'd512, 16'd71,  1'b0, 4'd1};
  case_table[3] = '{Shake, 10'd256, 16'd200, 1'b0, 4'd2};
  case_table[4] = '{Shake, 10'd256, 16'd200, 1'b1, 4'd2};
  case_table[5] = '{Sha3,  10'd224, 16'd144, 1'b1, 4'd2};
  case_table[6] = '{Sha3,  10'd384, 16'd103, 1'b0, 4'd1};
  case_table[7] = '{Shake, 10'd128, 16'd1,   1'b1, 4'd1};
endtask

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  if (state[0]) begin
    return (state >> 1) ^ LfsrTaps;
  end
  return state >> 1;
endfunction

function automatic keccak_strength_e strength_of(input int bits);
  case (bits)
    224:     return L224;
    256:     return L256;
    384:     return L384;
    512:     return L512;
    default: return L128;
  endcase
endfunction

// One LFSR step per message bit, LSB first
task automatic make_message(input int len);
  logic [7:0] byte_val;
  msg_lfsr = LfsrSeed;
  msg_bytes.delete();
  for (int i = 0; i < len; i++) begin
    for (int b = 0; b < 8; b++) begin
      byte_val[b] = msg_lfsr[0];
      msg_lfsr = lfsr_step(msg_lfsr);
    end
    msg_bytes.push_back(byte_val);
  end
endtask

// Message, suffix byte, zeros to a block boundary, 0x80 into the last byte
task automatic build_expected(input sha3_mode_e mode, input int rate_bytes);
  int last;
  exp_bytes = msg_bytes;
  exp_bytes.push_back((mode == Shake) ? 8'h1F : 8'h06);
  while (exp_bytes.size() % rate_bytes != 0) begin
    exp_bytes.push_back(8'h00);
  end
  last = exp_bytes.size() - 1;
  exp_bytes[last] = exp_bytes[last] | 8'h80;
endtask

// Words past the rate stay zero in the buffer
function automatic msg_word_t expected_word(input int blk, input int idx, input int rate_bytes);
  msg_word_t w;
  int        base;
  w = '0;
  if (idx < rate_bytes / 8) begin
    base = blk * rate_bytes + idx * 8;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = exp_bytes[base + b];
    end
  end
  return w;
endfunction

`endif

// ==== testbench/tb_sha3_pad.sv ====
/*
  Testbench for the SHA3/SHAKE padding stage
  Runs a table of messages and captures each block at keccak_run_o
  The Keccak model answers each run with keccak_complete_i 5 cycles later
*/
`timescale 1ns/1ps
`default_nettype none

module tb_sha3_pad;
  import sha3_pad_pkg::*;

  typedef msg_word_t [MsgEntries-1:0] block_t;

  localparam int TimeoutCycles = 2000;

  logic             clk_i = 1'b0;
  logic             rst_b;
  logic             msg_valid_i;
  msg_word_t        msg_data_i;
  msg_strb_t        msg_strb_i;
  logic             msg_ready_o;
  logic             start_i;
  logic             process_i;
  sha3_mode_e       mode_i;
  keccak_strength_e strength_i;
  block_t           keccak_data_o;
  logic             keccak_ready_i;
  logic             keccak_run_o;
  logic             keccak_complete_i;
  logic             absorbed_o;

  // Byte streams and captured blocks of the running test
  logic [7:0]  msg_bytes[$];
  logic [7:0]  exp_bytes[$];
  block_t      captured[$];

  logic [31:0] msg_lfsr;
  logic [31:0] ready_lfsr;
  logic        bp_on;
  int          cur_rate_words;
  int          full_words;
  int          absorbed_count;
  int          run_count;
  int          error_count;
  int          failed_tests;
  int          tests_run;
  bit          timed_out;

  `include "tb_sha3_pad_cases.svh"

  sha3_pad_top dut_i (.*);

  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Keccak model
  //////////////////////////////////////////////////////////////////////

  // Random ready under back-pressure, one LFSR bit per cycle
  always @(posedge clk_i) begin
    if (bp_on) begin
      keccak_ready_i <= ready_lfsr[0];
      ready_lfsr = lfsr_step(ready_lfsr);
    end else begin
      keccak_ready_i <= 1'b1;
    end
  end

  always begin
    @(negedge clk_i);
    if (rst_b && keccak_run_o) begin
      captured.push_back(keccak_data_o);
      repeat (5) @(posedge clk_i);
      keccak_complete_i <= 1'b1;
      @(posedge clk_i);
      keccak_complete_i <= 1'b0;
    end
  end

  // Ready must stay low while a full block waits for its run
  always @(negedge clk_i) begin
    if (rst_b) begin
      if (msg_ready_o && (full_words == cur_rate_words)) begin
        $display("At %0t msg_ready_o was high while a full block waited for its run", $time);
        error_count++;
      end
      if (keccak_run_o) begin
        full_words = 0;
        run_count++;
      end else if (msg_valid_i && msg_ready_o && (&msg_strb_i)) begin
        full_words++;
      end
      if (absorbed_o) begin
        absorbed_count++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Driver and checks
  //////////////////////////////////////////////////////////////////////

  task automatic wait_msg_ready(output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < TimeoutCycles) begin
      @(negedge clk_i);
      ok = msg_ready_o;
      cycles++;
    end
  endtask

  task automatic wait_absorbed(output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < TimeoutCycles) begin
      @(negedge clk_i);
      ok = absorbed_o;
      cycles++;
    end
  endtask

  // Called just after a rising edge; ends with the process_i pulse
  task automatic send_message(input int len);
    int        idx;
    bit        ok;
    msg_word_t data;
    msg_strb_t strb;
    for (int w = 0; w < (len + 7) / 8; w++) begin
      for (int b = 0; b < MsgStrbW; b++) begin
        idx = w * 8 + b;
        strb[b] = (idx < len);
        data[b*8 +: 8] = (idx < len) ? msg_bytes[idx] : 8'h00;
      end
      msg_valid_i <= 1'b1;
      msg_data_i  <= data;
      msg_strb_i  <= strb;
      wait_msg_ready(ok);
      if (!ok) begin
        $display("Timeout: msg_ready_o stayed low for message word %0d", w);
        timed_out = 1'b1;
        return;
      end
      @(posedge clk_i);
    end
    msg_valid_i <= 1'b0;
    process_i   <= 1'b1;
    @(posedge clk_i);
    process_i   <= 1'b0;
  endtask

  task automatic check_reset_state();
    int errors_before;
    errors_before = error_count;
    tests_run++;
    if (msg_ready_o !== 1'b0 || keccak_run_o !== 1'b0 || absorbed_o !== 1'b0) begin
      $display("Mismatch at %0t: msg_ready_o/keccak_run_o/absorbed_o got %b%b%b expected 000",
               $time, msg_ready_o, keccak_run_o, absorbed_o);
      error_count++;
    end
    if (keccak_data_o !== '0) begin
      $display("Mismatch at %0t: keccak_data_o got %h expected 0", $time, keccak_data_o);
      error_count++;
    end
    if (error_count != errors_before) begin
      failed_tests++;
    end
    $display("Test reset state: %s", (error_count == errors_before) ? "pass" : "FAIL");
  endtask

  task automatic check_blocks(input case_row_t row, input int rate_bytes);
    msg_word_t exp_word;
    if (run_count != int'(row.blocks)) begin
      $display("Mismatch at %0t: keccak_run_o pulse count got %0d expected %0d",
               $time, run_count, row.blocks);
      error_count++;
    end
    if (captured.size() != int'(row.blocks)) begin
      $display("Mismatch at %0t: captured block count got %0d expected %0d",
               $time, captured.size(), row.blocks);
      error_count++;
    end
    if (absorbed_count != 1) begin
      $display("Mismatch at %0t: absorbed_o pulse count got %0d expected 1",
               $time, absorbed_count);
      error_count++;
    end
    for (int k = 0; k < captured.size() && k < int'(row.blocks); k++) begin
      for (int j = 0; j < MsgEntries; j++) begin
        exp_word = expected_word(k, j, rate_bytes);
        if (captured[k][j] !== exp_word) begin
          $display("Mismatch at %0t: keccak_data_o block %0d word %0d got %h expected %h",
                   $time, k, j, captured[k][j], exp_word);
          error_count++;
        end
      end
    end
  endtask

  task automatic run_case(input int n);
    case_row_t row;
    int        rate_bytes;
    int        errors_before;
    bit        ok;
    row = case_table[n];
    rate_bytes = (1600 - 2 * int'(row.bits)) / 8;
    errors_before = error_count;
    tests_run++;
    make_message(int'(row.len));
    build_expected(row.mode, rate_bytes);
    captured.delete();
    cur_rate_words = rate_bytes / 8;
    full_words = 0;
    absorbed_count = 0;
    run_count = 0;
    bp_on <= row.bp;
    @(posedge clk_i);
    mode_i     <= row.mode;
    strength_i <= strength_of(int'(row.bits));
    start_i    <= 1'b1;
    @(posedge clk_i);
    start_i    <= 1'b0;
    send_message(int'(row.len));
    if (!timed_out) begin
      wait_absorbed(ok);
      if (!ok) begin
        $display("Timeout: absorbed_o never pulsed after process_i");
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      error_count++;
    end else begin
      // Room for a stray run or absorbed pulse to show up
      repeat (10) @(posedge clk_i);
      check_blocks(row, rate_bytes);
    end
    if (error_count != errors_before) begin
      failed_tests++;
    end
    $display("Test %0d %s-%0d, %0d bytes, back-pressure %0d: %s", n,
             (row.mode == Shake) ? "SHAKE" : "SHA3", row.bits, row.len, row.bp,
             (error_count == errors_before) ? "pass" : "FAIL");
  endtask

  initial begin
    rst_b             = 1'b0;
    msg_valid_i       = 1'b0;
    msg_data_i        = '0;
    msg_strb_i        = '0;
    start_i           = 1'b0;
    process_i         = 1'b0;
    mode_i            = Sha3;
    strength_i        = L128;
    keccak_ready_i    = 1'b0;
    keccak_complete_i = 1'b0;
    bp_on             = 1'b0;
    ready_lfsr        = LfsrSeed;
    cur_rate_words    = MsgEntries + 1;
    full_words        = 0;
    absorbed_count    = 0;
    run_count         = 0;
    error_count       = 0;
    failed_tests      = 0;
    tests_run         = 0;
    timed_out         = 1'b0;
    load_cases();
    repeat (3) @(posedge clk_i);
    rst_b <= 1'b1;
    @(negedge clk_i);
    check_reset_state();
    for (int n = 0; n < NumCases && !timed_out; n++) begin
      run_case(n);
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+testbench
verilog/sha3_pad_pkg.sv
verilog/msg_tail_buffer.sv
verilog/pad_ctrl_fsm.sv
verilog/block_buffer.sv
verilog/sha3_pad_top.sv
testbench/tb_sha3_pad.sv

// ==== Makefile ====
# Verilator simulation of the SHA3/SHAKE padding stage

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_sha3_pad
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
